/* Bender.yml */
package:
  name: seq_mult

sources:
  # synthesizable design, package first
  - files:
      - source/pkg_mult.sv
      - source/input_sync.sv
      - source/control.sv
      - source/shift_add_datapath.sv
      - source/result_display.sv
      - source/mult_top.sv

  # testbench, top module tb_mult_top
  - target: test
    files:
      - verification/clk_gen.sv
      - verification/tb_mult_top.sv

/* flist.f */
source/pkg_mult.sv
source/input_sync.sv
source/control.sv
source/shift_add_datapath.sv
source/result_display.sv
source/mult_top.sv
verification/clk_gen.sv
verification/tb_mult_top.sv

/* source/control.sv */
// control module: IDLE/INIT/ADD_SHIFT sequencer issuing load and clean and bounding the run

`timescale 1ns/1ps

module control #(
	parameter int MAX_CNTR = 9
) (
	input  logic i_clk,
	input  logic i_rst,
	// start button level, active low
	input  logic i_start,
	input  logic i_mltr_done,
	output logic o_load,
	output logic o_clean
);

	// counter wide enough to hold MAX_CNTR itself
	localparam int CNT_W = $clog2(MAX_CNTR + 1);

	pkg_mult::control_t r_control;
	pkg_mult::state_e   s_state_nxt;
	logic [CNT_W-1:0]   r_count;
	logic               s_run_end;

	// ========================================
	// end of run
	// ========================================

	// the run ends on the iteration limit or on early done from the datapath
	// count must be above zero so the done flag left over from the
	// previous product cannot end a run before load has cleared it
	assign s_run_end = (r_count != '0) &&
		((r_count >= CNT_W'(MAX_CNTR)) || i_mltr_done);

	// ========================================
	// next state
	// ========================================

	always_comb begin
		case (r_control.state)
			// a held button simply starts another run
			pkg_mult::IDLE: begin
				if (!i_start)
					s_state_nxt = pkg_mult::INIT;
				else
					s_state_nxt = pkg_mult::IDLE;
			end
			// one cycle to issue the load
			pkg_mult::INIT: begin
				s_state_nxt = pkg_mult::ADD_SHIFT;
			end
			pkg_mult::ADD_SHIFT: begin
				if (s_run_end)
					s_state_nxt = pkg_mult::IDLE;
				else
					s_state_nxt = pkg_mult::ADD_SHIFT;
			end
			default: begin
				s_state_nxt = pkg_mult::IDLE;
			end
		endcase
	end

	// ========================================
	// state and registered pulses
	// ========================================

	// load and clean are decoded from the current state and registered,
	// which places both in the first ADD_SHIFT cycle
	// clean sits high through reset so the product register is cleared
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			r_control.state <= pkg_mult::IDLE;
			r_control.load  <= 1'b0;
			r_control.clean <= 1'b1;
			r_count         <= '0;
		end else begin
			r_control.state <= s_state_nxt;
			r_control.load  <= (r_control.state == pkg_mult::INIT);
			r_control.clean <= (r_control.state == pkg_mult::INIT);
			// counts only while stepping, restarts from zero on every new run
			if (r_control.state == pkg_mult::ADD_SHIFT)
				r_count <= r_count + 1'b1;
			else
				r_count <= '0;
		end
	end

	assign o_load  = r_control.load;
	assign o_clean = r_control.clean;

endmodule

/* source/input_sync.sv */
// input_sync module: two-flop synchronizers for the start button and both operand buses

`timescale 1ns/1ps

module input_sync #(
	parameter int DATA_W = 8
) (
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_start_n,
	input  logic [DATA_W-1:0] i_mcand,
	input  logic [DATA_W-1:0] i_mplier,
	output logic              o_start_n,
	output logic [DATA_W-1:0] o_mcand,
	output logic [DATA_W-1:0] o_mplier
);

	// first and second stage of each chain
	logic [1:0]        r_start_n;
	logic [DATA_W-1:0] r_mcand_meta;
	logic [DATA_W-1:0] r_mplier_meta;
	logic [DATA_W-1:0] r_mcand;
	logic [DATA_W-1:0] r_mplier;

	// the button chain comes out of reset as released,
	// so the controller cannot see a press that never happened
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			r_start_n <= 2'b11;
		end else begin
			r_start_n <= {r_start_n[0], i_start_n};
		end
	end

	// operand switches only need to settle before the load pulse
	always_ff @(posedge i_clk) begin
		r_mcand_meta  <= i_mcand;
		r_mplier_meta <= i_mplier;
		r_mcand       <= r_mcand_meta;
		r_mplier      <= r_mplier_meta;
	end

	assign o_start_n = r_start_n[1];
	assign o_mcand   = r_mcand;
	assign o_mplier  = r_mplier;

endmodule

/* source/mult_top.sv */
// mult_top module: input synchronizers, controller, shift-add datapath and decimal display

`timescale 1ns/1ps

module mult_top #(
	parameter int DATA_W   = 8,
	parameter int MAX_CNTR = DATA_W + 1,
	parameter int DIGITS   = 5
) (
	input  logic                         i_clk,
	input  logic                         i_rst,
	input  logic                         i_start_n,
	input  logic [DATA_W-1:0]            i_multiplicand,
	input  logic [DATA_W-1:0]            i_multiplier,
	output pkg_mult::seg7_t [DIGITS-1:0] o_digits,
	output logic [2*DATA_W-1:0]          o_product,
	output logic                         o_valid
);

	// synchronized board inputs
	logic                s_start_n;
	logic [DATA_W-1:0]   s_mcand;
	logic [DATA_W-1:0]   s_mplier;

	// load and clean come from the control_t register inside the controller
	logic                s_load;
	logic                s_clean;

	logic [2*DATA_W-1:0] s_product;
	logic                s_mltr_done;

	// ========================================
	// input side
	// ========================================

	input_sync #(.DATA_W(DATA_W)) u_input_sync (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_start_n (i_start_n),
		.i_mcand   (i_multiplicand),
		.i_mplier  (i_multiplier),
		.o_start_n (s_start_n),
		.o_mcand   (s_mcand),
		.o_mplier  (s_mplier)
	);

	// ========================================
	// processing
	// ========================================

	control #(.MAX_CNTR(MAX_CNTR)) u_control (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_start     (s_start_n),
		.i_mltr_done (s_mltr_done),
		.o_load      (s_load),
		.o_clean     (s_clean)
	);

	// early done feeds back so short multipliers end the run sooner
	shift_add_datapath #(.DATA_W(DATA_W)) u_datapath (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_load      (s_load),
		.i_clean     (s_clean),
		.i_mcand     (s_mcand),
		.i_mplier    (s_mplier),
		.o_product   (s_product),
		.o_mltr_done (s_mltr_done)
	);

	// ========================================
	// output side
	// ========================================

	result_display #(.DATA_W(DATA_W), .DIGITS(DIGITS)) u_display (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_clean   (s_clean),
		.i_done    (s_mltr_done),
		.i_product (s_product),
		.o_product (o_product),
		.o_digits  (o_digits),
		.o_valid   (o_valid)
	);

endmodule

/* source/pkg_mult.sv */
// shared types: controller state enum, controller register struct, seven-segment pattern struct

package pkg_mult;

	// ========================================
	// controller types
	// ========================================

	// states of the multiplier sequencer
	// IDLE waits for the start button, INIT loads the operands,
	// ADD_SHIFT steps the datapath until the product is ready
	typedef enum logic [1:0] {
		IDLE      = 2'd0,
		INIT      = 2'd1,
		ADD_SHIFT = 2'd2
	} state_e;

	// registered outputs of the controller travel with its state
	// load and clean are both one-cycle pulses in the first ADD_SHIFT cycle
	typedef struct packed {
		state_e state;
		logic   load;
		logic   clean;
	} control_t;

	// ========================================
	// display types
	// ========================================

	// one seven-segment digit, active high
	// segment a is the top bar and the order runs clockwise to f,
	// g is the middle bar
	typedef struct packed {
		logic a;
		logic b;
		logic c;
		logic d;
		logic e;
		logic f;
		logic g;
	} seg7_t;

endpackage

/* source/result_display.sv */
// result_display module: binary to BCD by shift-and-add-3, seven-segment decode, valid level

`timescale 1ns/1ps

module result_display #(
	parameter int DATA_W = 8,
	parameter int DIGITS = 5
) (
	input  logic                             i_clk,
	input  logic                             i_rst,
	input  logic                             i_clean,
	input  logic                             i_done,
	input  logic [2*DATA_W-1:0]              i_product,
	output logic [2*DATA_W-1:0]              o_product,
	output pkg_mult::seg7_t [DIGITS-1:0]     o_digits,
	output logic                             o_valid
);

	logic [4*DIGITS-1:0]           s_bcd;
	pkg_mult::seg7_t [DIGITS-1:0]  s_segs;
	logic [2*DATA_W-1:0]           r_product;
	pkg_mult::seg7_t [DIGITS-1:0]  r_digits;
	logic                          r_valid;

	// segment pattern of one decimal digit, codes above 9 stay blank
	function automatic pkg_mult::seg7_t seg_decode(input logic [3:0] i_bcd);
		case (i_bcd)
			4'd0:    seg_decode = 7'b1111110;
			4'd1:    seg_decode = 7'b0110000;
			4'd2:    seg_decode = 7'b1101101;
			4'd3:    seg_decode = 7'b1111001;
			4'd4:    seg_decode = 7'b0110011;
			4'd5:    seg_decode = 7'b1011011;
			4'd6:    seg_decode = 7'b1011111;
			4'd7:    seg_decode = 7'b1110000;
			4'd8:    seg_decode = 7'b1111111;
			4'd9:    seg_decode = 7'b1111011;
			default: seg_decode = 7'b0000000;
		endcase
	endfunction

	// ========================================
	// binary to BCD
	// ========================================

	// product bits enter from the MSB, and before each shift any digit
	// above 4 gets 3 added so it carries correctly into the next decade
	always_comb begin : bin_to_bcd
		logic [4*DIGITS-1:0] v_bcd;
		v_bcd = '0;
		for (int i = 2*DATA_W-1; i >= 0; i--) begin
			for (int d = 0; d < DIGITS; d++) begin
				if (v_bcd[4*d +: 4] > 4'd4)
					v_bcd[4*d +: 4] = v_bcd[4*d +: 4] + 4'd3;
			end
			v_bcd = {v_bcd[4*DIGITS-2:0], i_product[i]};
		end
		s_bcd = v_bcd;
	end

	// element 0 is the units digit
	always_comb begin
		for (int d = 0; d < DIGITS; d++)
			s_segs[d] = seg_decode(s_bcd[4*d +: 4]);
	end

	// ========================================
	// output registers
	// ========================================

	// product and digits follow the datapath every cycle, which leaves
	// them settled on the final value by the time valid rises
	// valid trails done by one cycle and drops as soon as a new run cleans
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			r_product <= '0;
			r_digits  <= '0;
			r_valid   <= 1'b0;
		end else begin
			r_product <= i_product;
			r_digits  <= s_segs;
			r_valid   <= i_done && !i_clean;
		end
	end

	assign o_product = r_product;
	assign o_digits  = r_digits;
	assign o_valid   = r_valid;

endmodule

/* source/shift_add_datapath.sv */
// shift_add_datapath module: operand, product and remaining-multiplier registers with early done

`timescale 1ns/1ps

module shift_add_datapath #(
	parameter int DATA_W = 8
) (
	input  logic                i_clk,
	input  logic                i_rst,
	input  logic                i_load,
	input  logic                i_clean,
	input  logic [DATA_W-1:0]   i_mcand,
	input  logic [DATA_W-1:0]   i_mplier,
	output logic [2*DATA_W-1:0] o_product,
	output logic                o_mltr_done
);

	// multiplicand is held at product width so it can shift left freely
	logic [2*DATA_W-1:0] r_mcand;
	logic [DATA_W-1:0]   r_mplier;
	logic [2*DATA_W-1:0] r_product;
	logic                r_busy;
	logic                r_done;
	logic                s_last_step;

	// the current step is the last one when no set bit remains above bit 0
	assign s_last_step = (r_mplier[DATA_W-1:1] == '0);

	// ========================================
	// run control
	// ========================================

	// busy gates the stepping, so nothing moves between runs or after reset
	// done rises with the final add and holds until the next load
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			r_busy <= 1'b0;
			r_done <= 1'b0;
		end else if (i_load) begin
			r_busy <= 1'b1;
			r_done <= 1'b0;
		end else if (i_clean) begin
			r_busy <= 1'b0;
			r_done <= 1'b0;
		end else if (r_busy && s_last_step) begin
			r_busy <= 1'b0;
			r_done <= 1'b1;
		end
	end

	// ========================================
	// add and shift
	// ========================================

	// one conditional add per cycle, then the multiplier moves right
	// and the multiplicand moves left to the weight of the next bit
	// a zero multiplier takes a single step that adds nothing
	always_ff @(posedge i_clk) begin
		if (i_load) begin
			r_mcand   <= {{DATA_W{1'b0}}, i_mcand};
			r_mplier  <= i_mplier;
			r_product <= '0;
		end else if (i_clean) begin
			r_product <= '0;
		end else if (r_busy) begin
			if (r_mplier[0])
				r_product <= r_product + r_mcand;
			r_mcand  <= r_mcand << 1;
			r_mplier <= r_mplier >> 1;
		end
	end

	assign o_product   = r_product;
	assign o_mltr_done = r_done;

endmodule

/* verification/clk_gen.sv */
// clk_gen module: testbench clock with an 8 ns period and an active-low reset held for 4 cycles

`timescale 1ns/1ps

module clk_gen #(
	parameter int HALF_NS    = 4,
	parameter int RST_CYCLES = 4
) (
	output logic o_clk,
	output logic o_rst
);

	initial begin
		o_clk = 1'b0;
		forever #(HALF_NS) o_clk = ~o_clk;
	end

	// reset is released on a falling edge, away from the capturing edge
	initial begin
		o_rst = 1'b0;
		repeat (RST_CYCLES) @(posedge o_clk);
		@(negedge o_clk);
		o_rst = 1'b1;
	end

endmodule

/* verification/tb_mult_top.sv */
// tb_mult_top module: stimulus, xorshift operands, reference model, assertions, timeout, summary

`timescale 1ns/1ps

module tb_mult_top;

	localparam int DATA_W      = 8;
	localparam int DIGITS      = 5;
	localparam int NUM_RUNS    = 40;
	localparam int RUN_CYCLES  = 20;
	localparam int TIMEOUT_CYC = NUM_RUNS * RUN_CYCLES + 100;
	// start sync, controller to load, output register, as counted in falling edges
	localparam int SYNC_CYC    = 2;
	localparam int CTRL_CYC    = 2;
	localparam int OUT_CYC     = 2;
	// valid drops one edge after the clean pulse that follows the load request
	localparam int FALL_MAX    = SYNC_CYC + CTRL_CYC + 1;

	logic                         i_clk;
	logic                         i_rst;
	logic                         i_start_n;
	logic [DATA_W-1:0]            i_multiplicand;
	logic [DATA_W-1:0]            i_multiplier;
	pkg_mult::seg7_t [DIGITS-1:0] o_digits;
	logic [2*DATA_W-1:0]          o_product;
	logic                         o_valid;

	logic [2*DATA_W-1:0] exp_product;
	logic [31:0]         rnd;
	int unsigned         cyc = 0;
	int                  err_value = 0;
	int                  err_timing = 0;
	int                  err_reset = 0;
	int                  runs = 0;

	clk_gen u_clk_gen (
		.o_clk (i_clk),
		.o_rst (i_rst)
	);

	mult_top #(.DATA_W(DATA_W), .DIGITS(DIGITS)) u_dut (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_start_n      (i_start_n),
		.i_multiplicand (i_multiplicand),
		.i_multiplier   (i_multiplier),
		.o_digits       (o_digits),
		.o_product      (o_product),
		.o_valid        (o_valid)
	);

	// ========================================
	// reference model
	// ========================================

	// 32-bit xorshift step
	function automatic logic [31:0] next_rand(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// segments lit per digit, worked out bar by bar from the shape of each numeral
	function automatic pkg_mult::seg7_t seg_of(input int digit);
		pkg_mult::seg7_t s;
		s.a = !(digit inside {1, 4});
		s.b = !(digit inside {5, 6});
		s.c = (digit != 2);
		s.d = !(digit inside {1, 4, 7});
		s.e = (digit inside {0, 2, 6, 8});
		s.f = !(digit inside {1, 2, 3, 7});
		s.g = !(digit inside {0, 1, 7});
		return s;
	endfunction

	// units digit lands in element 0
	function automatic logic [7*DIGITS-1:0] expect_digits(input logic [2*DATA_W-1:0] v);
		logic [7*DIGITS-1:0] res;
		int                  rest;
		rest = v;
		for (int d = 0; d < DIGITS; d++) begin
			res[7*d +: 7] = seg_of(rest % 10);
			rest = rest / 10;
		end
		return res;
	endfunction

	task automatic print_counts();
		$display("runs %0d, value errors %0d, timing errors %0d, reset errors %0d",
			runs, err_value, err_timing, err_reset);
	endtask

	// ========================================
	// assertions
	// ========================================

	always_ff @(posedge i_clk) cyc <= cyc + 1;

	// exp_product only moves while valid is low, so a held result is always compared
	// with the operands of the run that produced it
	product_check: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_valid |-> (o_product == exp_product))
		else begin
			err_value++;
			$display("** Error at %0t: product %0d, expected %0d",
				$time, $sampled(o_product), exp_product);
		end

	digits_check: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_valid |-> (o_digits == expect_digits(exp_product)))
		else begin
			err_value++;
			$display("** Error at %0t: digits %h do not show %0d",
				$time, $sampled(o_digits), exp_product);
		end

	// reset window covers the held reset and the two cycles after release
	reset_check: assert property (@(negedge i_clk)
		(cyc < 7) |-> (!o_valid && o_product == '0))
		else begin
			err_reset++;
			$display("** Error at %0t: valid %b product %0d around reset",
				$time, $sampled(o_valid), $sampled(o_product));
		end

	// ========================================
	// stimulus
	// ========================================

	// one press with held operands, observed on falling edges only
	task automatic run_product(input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
		int n;
		int fall_n;
		int rise_n;
		int steps;
		bit fell;
		bit was_valid;
		n = 0;
		fall_n = 0;
		rise_n = 0;
		fell = 1'b0;
		steps = 1;
		for (int i = 0; i < DATA_W; i++) begin
			if (b[i])
				steps = i + 1;
		end
		@(negedge i_clk);
		was_valid = o_valid;
		i_multiplicand = a;
		i_multiplier = b;
		i_start_n = 1'b0;
		while (rise_n == 0) begin
			@(negedge i_clk);
			n++;
			if (n == 3)
				i_start_n = 1'b1;
			if (!fell && !o_valid) begin
				fell = 1'b1;
				fall_n = n;
				exp_product = {{DATA_W{1'b0}}, a} * {{DATA_W{1'b0}}, b};
			end else if (fell && o_valid) begin
				rise_n = n;
			end
		end
		runs++;
		assert (!was_valid || fall_n <= FALL_MAX)
			else begin
				err_timing++;
				$display("** Error at %0t: valid fell %0d cycles after start, limit %0d",
					$time, fall_n, FALL_MAX);
			end
		// a short multiplier has to finish early, and the widest one sets the full-width bound
		assert (rise_n <= SYNC_CYC + CTRL_CYC + steps + OUT_CYC)
			else begin
				err_timing++;
				$display("** Error at %0t: %0d x %0d took %0d cycles, limit %0d",
					$time, a, b, rise_n, SYNC_CYC + CTRL_CYC + steps + OUT_CYC);
			end
		assert (b != 0 || o_product == '0)
			else begin
				err_value++;
				$display("** Error at %0t: zero multiplier gave %0d", $time, o_product);
			end
	endtask

	initial begin
		i_start_n = 1'b1;
		i_multiplicand = '0;
		i_multiplier = '0;
		exp_product = '0;
		rnd = 32'h8b09;
		wait (i_rst);
		repeat (3) @(negedge i_clk);
		// directed corners first
		run_product(8'd37, 8'd1);
		run_product(8'd200, 8'd0);
		run_product(8'd255, 8'd255);
		run_product(8'd0, 8'd255);
		run_product(8'd12, 8'd34);
		run_product(8'd1, 8'd128);
		// the multiplier is shifted down by a random amount to spread its top bit
		while (runs < NUM_RUNS) begin
			rnd = next_rand(rnd);
			run_product(rnd[7:0], rnd[15:8] >> rnd[18:16]);
		end
		repeat (2) @(negedge i_clk);
		print_counts();
		if (err_value + err_timing + err_reset == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin : watchdog
		wait (cyc >= TIMEOUT_CYC);
		$display("timeout: the DUT gave no result within %0d cycles", TIMEOUT_CYC);
		print_counts();
		$display("sim failed");
		$finish;
	end

endmodule
